//--- source/div_pkg.sv
// Shared widths, types and latency constants for the 16-bit integer divider
// Imported by wildcard in every divider module and in the testbench

package div_pkg;

  // Operand and result width
  localparam int DATA_WIDTH = 16;

  // Go-to-done latency for a nonzero dividend
  localparam int DIV_LATENCY = DATA_WIDTH + 3;

  // Go-to-done latency when the dividend is zero
  localparam int ZERO_LATENCY = 3;

  // Dividend, divisor, quotient and remainder
  typedef logic [DATA_WIDTH-1:0] word_t;

  // Divisor as it is shifted across the dividend in the core
  typedef logic [2*DATA_WIDTH-2:0] shift_t;

  // Registered operands handed to the core and the sign stage
  typedef struct packed {
    word_t dividend_mag;
    word_t divisor_mag;
    logic  left_neg;
    logic  right_neg;
  } div_operands_t;

  // Quotient and remainder pair
  typedef struct packed {
    word_t quotient;
    word_t remainder;
  } div_result_t;

  // Core FSM
  typedef enum logic {
    CORE_IDLE = 1'b0,
    CORE_RUN  = 1'b1
  } core_state_t;

endpackage

//--- source/div_operand_stage.sv
// Operand stage of the divider pipeline
// Captures dividend and divisor on go and turns them into magnitudes plus sign flags
// Also produces the one-cycle start strobe for the core

`timescale 1ns/1ps

module div_operand_stage import div_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          go,
  input  logic          is_signed,
  input  word_t         dividend,
  input  word_t         divisor,
  output div_operands_t operands,
  output logic          start
);

  div_operands_t operands_next;
  logic          dividend_neg;
  logic          divisor_neg;

  // An operand only counts as negative in signed mode
  assign dividend_neg = is_signed & dividend[DATA_WIDTH-1];
  assign divisor_neg  = is_signed & divisor[DATA_WIDTH-1];

  // Two's-complement magnitudes
  // The most negative value maps onto itself, which is the right unsigned magnitude
  always_comb begin
    operands_next.left_neg  = dividend_neg;
    operands_next.right_neg = divisor_neg;

    if (dividend_neg) begin
      operands_next.dividend_mag = word_t'(-dividend);
    end else begin
      operands_next.dividend_mag = dividend;
    end

    if (divisor_neg) begin
      operands_next.divisor_mag = word_t'(-divisor);
    end else begin
      operands_next.divisor_mag = divisor;
    end
  end

  // Operands stay put until the next go
  always_ff @(posedge clk) begin
    if (go) begin
      operands <= operands_next;
    end
  end

  // Core starts one cycle after go, once the operands are stable
  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= go;
    end
  end

endmodule

//--- source/div_restoring_core.sv
// Unsigned restoring divider core, one quotient bit per cycle
// start loads the magnitudes, core_done pulses for one cycle when raw is valid
// Only one division is held at a time; start must not come while a division runs

`timescale 1ns/1ps

module div_restoring_core import div_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  word_t       dividend_mag,
  input  word_t       divisor_mag,
  output div_result_t raw,
  output logic        core_done
);

  core_state_t state;
  word_t       quotient_mask;
  word_t       quotient;
  word_t       partial;
  shift_t      divisor_shift;
  logic        load;
  logic        stepping;
  logic        finished;
  logic        fits;

  assign load     = start && (state == CORE_IDLE);
  assign stepping = (state == CORE_RUN) && (quotient_mask != '0);
  assign finished = (state == CORE_RUN) && (quotient_mask == '0);

  // Shifted divisor fits into what is left of the dividend
  assign fits = divisor_shift <= shift_t'(partial);

  // FSM and done pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= CORE_IDLE;
      core_done <= 1'b0;
    end else begin
      core_done <= finished;
      case (state)
        CORE_IDLE: begin
          if (start) begin
            state <= CORE_RUN;
          end
        end
        CORE_RUN: begin
          if (finished) begin
            state <= CORE_IDLE;
          end
        end
        default: begin
          state <= CORE_IDLE;
        end
      endcase
    end
  end

  // Quotient mask walks from the top bit down to empty
  // A zero dividend loads an empty mask and leaves RUN right away
  always_ff @(posedge clk) begin
    if (reset) begin
      quotient_mask <= '0;
    end else if (load) begin
      if (dividend_mag == '0) begin
        quotient_mask <= '0;
      end else begin
        quotient_mask <= {1'b1, {(DATA_WIDTH-1){1'b0}}};
      end
    end else if (stepping) begin
      quotient_mask <= quotient_mask >> 1;
    end
  end

  // Restoring step
  // The divisor starts aligned under the top dividend bit and moves right each cycle
  always_ff @(posedge clk) begin
    if (load) begin
      quotient      <= '0;
      partial       <= dividend_mag;
      divisor_shift <= {divisor_mag, {(DATA_WIDTH-1){1'b0}}};
    end else if (stepping) begin
      divisor_shift <= divisor_shift >> 1;
      if (fits) begin
        // fits implies the upper bits of the shifted divisor are zero
        partial  <= partial - divisor_shift[DATA_WIDTH-1:0];
        quotient <= quotient | quotient_mask;
      end
    end
  end

  // Registers stop moving once the mask is empty, so raw holds through core_done
  // Zero divisor always fits, giving all-ones quotient and the dividend as remainder
  assign raw.quotient  = quotient;
  assign raw.remainder = partial;

  // The operand stage may only send a new start after done
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (reset)
    start |-> (state == CORE_IDLE)
  ) else $error("start arrived while the core was busy");

  a_core_done_pulse: assert property (
    @(posedge clk) disable iff (reset)
    core_done |=> !core_done
  ) else $error("core_done held for more than one cycle");

  // Operand magnitudes are held by the operand stage for the whole division
  a_remainder_range: assert property (
    @(posedge clk) disable iff (reset)
    (core_done && (divisor_mag != '0)) |-> (raw.remainder < divisor_mag)
  ) else $error("remainder not below divisor");

endmodule

//--- source/div_sign_stage.sv
// Sign stage of the divider pipeline
// Turns the unsigned core result into the signed result and registers it with done
// Quotient truncates toward zero, a nonzero remainder takes the divisor's sign

`timescale 1ns/1ps

module div_sign_stage import div_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  div_operands_t operands,
  input  div_result_t   raw,
  input  logic          core_done,
  output div_result_t   result,
  output logic          done
);

  div_result_t corrected;
  logic        signs_differ;
  word_t       remainder_floor;

  assign signs_differ = operands.left_neg ^ operands.right_neg;

  // Flip the remainder over to the other side of the divisor when the signs differ
  always_comb begin
    if (signs_differ && (raw.remainder != '0)) begin
      remainder_floor = word_t'(operands.divisor_mag - raw.remainder);
    end else begin
      remainder_floor = raw.remainder;
    end
  end

  always_comb begin
    if (signs_differ) begin
      corrected.quotient = word_t'(-raw.quotient);
    end else begin
      corrected.quotient = raw.quotient;
    end

    if (operands.right_neg) begin
      corrected.remainder = word_t'(-remainder_floor);
    end else begin
      corrected.remainder = remainder_floor;
    end
  end

  // Result holds from one done to the next
  always_ff @(posedge clk) begin
    if (core_done) begin
      result <= corrected;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= core_done;
    end
  end

  a_done_pulse: assert property (
    @(posedge clk) disable iff (reset)
    done |=> !done
  ) else $error("done high for two cycles in a row");

endmodule

//--- source/int_divider.sv
// 16-bit integer divider, unsigned or signed
// Pulse go with is_signed, dividend and divisor valid on the same edge
// done pulses DIV_LATENCY cycles later, or ZERO_LATENCY cycles for a zero dividend
// quotient and remainder hold until the next done

`timescale 1ns/1ps

module int_divider import div_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  go,
  input  logic  is_signed,
  input  word_t dividend,
  input  word_t divisor,
  output word_t quotient,
  output word_t remainder,
  output logic  done
);

  div_operands_t operands;
  div_result_t   raw;
  div_result_t   result;
  logic          start;
  logic          core_done;

  div_operand_stage operand_stage (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .is_signed (is_signed),
    .dividend  (dividend),
    .divisor   (divisor),
    .operands  (operands),
    .start     (start)
  );

  // Core only ever sees magnitudes
  div_restoring_core core (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .dividend_mag (operands.dividend_mag),
    .divisor_mag  (operands.divisor_mag),
    .raw          (raw),
    .core_done    (core_done)
  );

  div_sign_stage sign_stage (
    .clk       (clk),
    .reset     (reset),
    .operands  (operands),
    .raw       (raw),
    .core_done (core_done),
    .result    (result),
    .done      (done)
  );

  assign quotient  = result.quotient;
  assign remainder = result.remainder;

endmodule

//--- tests/div_vectors.svh
// Directed stimulus table for the integer divider testbench
// Included inside the testbench module, fill_directed_vectors loads the rows

`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// Columns: is_signed, dividend, divisor, expected quotient, expected remainder
typedef struct packed {
  logic  is_signed;
  word_t dividend;
  word_t divisor;
  word_t quotient;
  word_t remainder;
} div_vector_t;

localparam int NUM_DIRECTED = 25;

div_vector_t directed_vectors [NUM_DIRECTED];

task automatic fill_directed_vectors();
  // Unsigned
  directed_vectors[0]  = {1'b0, 16'h0064, 16'h0007, 16'h000E, 16'h0002};
  directed_vectors[1]  = {1'b0, 16'hFFFF, 16'h0001, 16'hFFFF, 16'h0000};
  directed_vectors[2]  = {1'b0, 16'hFFFF, 16'hFFFF, 16'h0001, 16'h0000};
  directed_vectors[3]  = {1'b0, 16'h0005, 16'h0009, 16'h0000, 16'h0005};
  directed_vectors[4]  = {1'b0, 16'h8000, 16'h0003, 16'h2AAA, 16'h0002};
  directed_vectors[5]  = {1'b0, 16'hABCD, 16'h0010, 16'h0ABC, 16'h000D};
  directed_vectors[6]  = {1'b0, 16'hFFF9, 16'h0002, 16'h7FFC, 16'h0001};
  // Unsigned zero divisor
  directed_vectors[7]  = {1'b0, 16'h04D2, 16'h0000, 16'hFFFF, 16'h04D2};
  directed_vectors[8]  = {1'b0, 16'hFFFF, 16'h0000, 16'hFFFF, 16'hFFFF};
  // Zero dividend takes the early exit
  directed_vectors[9]  = {1'b0, 16'h0000, 16'h0005, 16'h0000, 16'h0000};
  directed_vectors[10] = {1'b0, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
  directed_vectors[11] = {1'b1, 16'h0000, 16'hFFF0, 16'h0000, 16'h0000};
  // Signed, all four sign combinations
  directed_vectors[12] = {1'b1, 16'h0007, 16'h0002, 16'h0003, 16'h0001};
  directed_vectors[13] = {1'b1, 16'hFFF9, 16'h0002, 16'hFFFD, 16'h0001};
  directed_vectors[14] = {1'b1, 16'h0007, 16'hFFFE, 16'hFFFD, 16'hFFFF};
  directed_vectors[15] = {1'b1, 16'hFFF9, 16'hFFFE, 16'h0003, 16'hFFFF};
  directed_vectors[16] = {1'b1, 16'h0064, 16'hFFF9, 16'hFFF2, 16'hFFFB};
  directed_vectors[17] = {1'b1, 16'hFF9C, 16'hFFF9, 16'h000E, 16'hFFFE};
  directed_vectors[18] = {1'b1, 16'h0006, 16'hFFFD, 16'hFFFE, 16'h0000};
  directed_vectors[19] = {1'b1, 16'hFFFA, 16'h0004, 16'hFFFF, 16'h0002};
  // Most negative values
  directed_vectors[20] = {1'b1, 16'h8000, 16'hFFFF, 16'h8000, 16'h0000};
  directed_vectors[21] = {1'b1, 16'h8000, 16'h0001, 16'h8000, 16'h0000};
  directed_vectors[22] = {1'b1, 16'h0005, 16'h8000, 16'h0000, 16'h8005};
  directed_vectors[23] = {1'b1, 16'h8000, 16'h7FFF, 16'hFFFF, 16'h7FFE};
  directed_vectors[24] = {1'b1, 16'h7FFF, 16'h7FFF, 16'h0001, 16'h0000};
endtask

`endif

//--- tests/int_divider_tb.sv
// Testbench for the 16-bit integer divider
// Applies a directed table, then seeded random cases checked against the division rules
// Also checks go-to-done latency, the done pulse width and that results hold between dones

`timescale 1ns/1ps

module int_divider_tb import div_pkg::*; ();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 200;

  `include "div_vectors.svh"

  localparam int NUM_CASES       = NUM_DIRECTED + NUM_RANDOM;
  localparam int WATCHDOG_CYCLES = NUM_CASES * (DIV_LATENCY + 4) + RESET_CYCLES;

  logic        clk;
  logic        reset;
  logic        go;
  logic        is_signed;
  word_t       dividend;
  word_t       divisor;
  word_t       quotient;
  word_t       remainder;
  logic        done;
  logic [31:0] rng_state;
  logic        have_previous;
  word_t       previous_quotient;
  word_t       previous_remainder;

  int_divider UUT (
    .clk       (clk),
    .reset     (reset),
    .go        (go),
    .is_signed (is_signed),
    .dividend  (dividend),
    .divisor   (divisor),
    .quotient  (quotient),
    .remainder (remainder),
    .done      (done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(input string message);
    $display("%s", message);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0d ns: %s is 0x%h, expected 0x%h",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_latency(input string what, input int actual, input int expected);
    if (actual != expected) begin
      fail_run($sformatf("Error at %0d ns: %s took %0d cycles, expected %0d",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0d ns: %s is %b, expected %b",
                         $time, what, actual, expected));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected result from the division rules
  // Signed quotient truncates and a nonzero remainder moves to the divisor's sign
  function automatic div_result_t expected_result(input logic mode, input word_t a,
                                                  input word_t b);
    div_result_t expected;
    int          sa;
    int          sb;
    int          q;
    int          r;
    sa = $signed(a);
    sb = $signed(b);
    if (a == '0) begin
      expected.quotient  = '0;
      expected.remainder = '0;
    end else if (!mode && (b == '0)) begin
      expected.quotient  = '1;
      expected.remainder = a;
    end else if (!mode) begin
      expected.quotient  = a / b;
      expected.remainder = a % b;
    end else begin
      q = sa / sb;
      r = sa % sb;
      if ((r != 0) && ((sa < 0) != (sb < 0))) begin
        r = r + sb;
      end
      expected.quotient  = word_t'(q);
      expected.remainder = word_t'(r);
    end
    return expected;
  endfunction

  // One division that pulses go, waits for done, then checks the result and its hold
  task automatic run_case(input logic mode, input word_t a, input word_t b,
                          input word_t exp_q, input word_t exp_r);
    int    cycles;
    int    expected_latency;
    logic  seen;
    string label;
    label            = $sformatf("%s 0x%h / 0x%h", mode ? "signed" : "unsigned", a, b);
    expected_latency = (a == '0) ? ZERO_LATENCY : DIV_LATENCY;
    go               = 1'b1;
    is_signed        = mode;
    dividend         = a;
    divisor          = b;
    @(posedge clk);
    #1;
    // Scramble the inputs so only the value sampled with go counts
    go        = 1'b0;
    is_signed = ~mode;
    dividend  = ~a;
    divisor   = ~b;
    cycles    = 0;
    seen      = 1'b0;
    while (!seen) begin
      @(posedge clk);
      #1;
      cycles++;
      if (done === 1'b1) begin
        seen = 1'b1;
      end else begin
        if (have_previous) begin
          check_word({label, " quotient hold"}, quotient, previous_quotient);
          check_word({label, " remainder hold"}, remainder, previous_remainder);
        end
        if (cycles >= DIV_LATENCY + 4) begin
          fail_run({"done never arrived for ", label});
        end
      end
    end
    check_latency({label, " latency"}, cycles, expected_latency);
    check_word({label, " quotient"}, quotient, exp_q);
    check_word({label, " remainder"}, remainder, exp_r);
    previous_quotient  = quotient;
    previous_remainder = remainder;
    have_previous      = 1'b1;
    @(posedge clk);
    #1;
    check_flag({label, " done width"}, done, 1'b0);
    check_word({label, " quotient after done"}, quotient, exp_q);
    check_word({label, " remainder after done"}, remainder, exp_r);
  endtask

  initial begin
    logic        mode;
    word_t       a;
    word_t       b;
    div_result_t expected;
    clk           = 1'b0;
    reset         = 1'b1;
    go            = 1'b0;
    is_signed     = 1'b0;
    dividend      = '0;
    divisor       = '0;
    rng_state     = 32'd9;
    have_previous = 1'b0;
    fill_directed_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    // done must stay low until the first go
    repeat (4) begin
      @(posedge clk);
      #1;
      check_flag("done after reset", done, 1'b0);
    end

    for (int i = 0; i < NUM_DIRECTED; i++) begin
      run_case(directed_vectors[i].is_signed, directed_vectors[i].dividend,
               directed_vectors[i].divisor, directed_vectors[i].quotient,
               directed_vectors[i].remainder);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      rng_state = xorshift32(rng_state);
      a         = rng_state[15:0];
      b         = rng_state[31:16];
      rng_state = xorshift32(rng_state);
      mode      = rng_state[0];
      // Small divisors and dividends now and then
      if (rng_state[2:1] == 2'b00) begin
        b = b >> 10;
      end
      if (rng_state[4:3] == 2'b00) begin
        a = a >> 9;
      end
      if (mode && (b == '0)) begin
        b = 16'h0001;
      end
      expected = expected_result(mode, a, b);
      run_case(mode, a, b, expected.quotient, expected.remainder);
    end

    $display("TEST PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("Simulation timed out before all cases finished");
  end

endmodule

//--- int_divider.f
+incdir+tests
source/div_pkg.sv
source/div_operand_stage.sv
source/div_restoring_core.sv
source/div_sign_stage.sv
source/int_divider.sv
tests/int_divider_tb.sv
